//--- logic/ntm_arith_pkg.sv
`default_nettype none

package ntm_arith_pkg;

  ////////////////////////////////////////
  // Operation codes
  ////////////////////////////////////////

  // Element operation selected by the host per job
  typedef enum logic {
    // a + b, reduced mod modulo
    OP_ADD = 1'b0,
    // a - b, wrapped into 0 .. modulo-1
    OP_SUB = 1'b1
  } op_t;

  ////////////////////////////////////////
  // Default widths
  ////////////////////////////////////////

  // Operand and modulus width
  localparam int DATA_SIZE_DEFAULT = 32;

  // Width of the matrix sizes and the loop counters
  localparam int INDEX_SIZE_DEFAULT = 8;

endpackage

`default_nettype wire

//--- logic/ntm_scalar_adder.sv
`timescale 1ns/1ps
`default_nettype none

module ntm_scalar_adder #(
  parameter int DATA_SIZE = ntm_arith_pkg::DATA_SIZE_DEFAULT
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Operand pair, valid while operand_strobe is high
  input  logic                   operand_strobe,
  input  ntm_arith_pkg::op_t     operation,
  input  logic [DATA_SIZE-1:0]   modulo,
  input  logic [DATA_SIZE-1:0]   a,
  input  logic [DATA_SIZE-1:0]   b,

  // Reduced result, one cycle after the strobe
  output logic [DATA_SIZE-1:0]   result,
  output logic                   result_valid
);

  import ntm_arith_pkg::*;

  ////////////////////////////////////////
  // Extended operands
  ////////////////////////////////////////

  // One guard bit so a + b and a + modulo never overflow
  logic [DATA_SIZE:0] a_ext;
  logic [DATA_SIZE:0] b_ext;
  logic [DATA_SIZE:0] mod_ext;
  logic [DATA_SIZE:0] sum_ext;
  logic [DATA_SIZE:0] next_ext;

  assign a_ext   = {1'b0, a};
  assign b_ext   = {1'b0, b};
  assign mod_ext = {1'b0, modulo};
  assign sum_ext = a_ext + b_ext;

  ////////////////////////////////////////
  // Modular reduction
  ////////////////////////////////////////

  always_comb begin
    if (operation == OP_ADD) begin
      // Both operands below modulus, a single correction is enough
      if (sum_ext >= mod_ext) begin
        next_ext = sum_ext - mod_ext;
      end else begin
        next_ext = sum_ext;
      end
    end else begin
      // Negative difference wraps by adding the modulus first
      if (a_ext >= b_ext) begin
        next_ext = a_ext - b_ext;
      end else begin
        next_ext = a_ext + mod_ext - b_ext;
      end
    end
  end

  // Valid pulse follows the strobe by one cycle
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= operand_strobe;
    end
  end

  // Result register, top guard bit is always zero here
  always_ff @(posedge CLK) begin
    if (operand_strobe) begin
      result <= next_ext[DATA_SIZE-1:0];
    end
  end

endmodule

`default_nettype wire

//--- logic/ntm_vector_adder.sv
`timescale 1ns/1ps
`default_nettype none

module ntm_vector_adder #(
  parameter int DATA_SIZE  = ntm_arith_pkg::DATA_SIZE_DEFAULT,
  parameter int INDEX_SIZE = ntm_arith_pkg::INDEX_SIZE_DEFAULT
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Row control
  input  logic                   start,
  input  ntm_arith_pkg::op_t     operation,
  input  logic [DATA_SIZE-1:0]   modulo,
  input  logic [INDEX_SIZE-1:0]  size,

  // Input four-phase port
  input  logic                   in_req,
  output logic                   in_ack,
  input  logic [DATA_SIZE-1:0]   data_a,
  input  logic [DATA_SIZE-1:0]   data_b,

  // Output four-phase port
  output logic                   out_req,
  input  logic                   out_ack,
  output logic [DATA_SIZE-1:0]   data_out,
  output logic                   row_end,

  // One cycle after the last element handshake
  output logic                   row_done
);

  typedef enum logic [2:0] {IDLE, WAIT_IN, CALC, SEND, WAIT_DROP} vector_state_t;

  localparam logic [INDEX_SIZE-1:0] IDX_ONE = 1;

  vector_state_t         state;
  logic [INDEX_SIZE-1:0] elem_cnt;
  logic                  last_elem;
  logic                  take_pair;
  logic [DATA_SIZE-1:0]  sum_result;
  logic                  sum_valid;

  // Final element of the row
  assign last_elem = (elem_cnt == size - IDX_ONE);

  // New pair only once the previous ack is back low
  assign take_pair = (state == WAIT_IN) && in_req && !in_ack;

  ////////////////////////////////////////
  // Element arithmetic
  ////////////////////////////////////////

  // Operands captured straight from the port on the ack edge
  ntm_scalar_adder #(
    .DATA_SIZE(DATA_SIZE)
  ) u_scalar_adder (
    .CLK(CLK),
    .RST(RST),
    .operand_strobe(take_pair),
    .operation(operation),
    .modulo(modulo),
    .a(data_a),
    .b(data_b),
    .result(sum_result),
    .result_valid(sum_valid)
  );

  ////////////////////////////////////////
  // Element loop and handshakes
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= IDLE;
      elem_cnt <= '0;
      in_ack   <= 1'b0;
      out_req  <= 1'b0;
      data_out <= '0;
      row_end  <= 1'b0;
      row_done <= 1'b0;
    end else begin
      row_done <= 1'b0;
      // Input ack release, may overlap the calculation
      if (in_ack && !in_req) begin
        in_ack <= 1'b0;
      end
      case (state)
        IDLE: begin
          if (start) begin
            elem_cnt <= '0;
            state    <= WAIT_IN;
          end
        end
        WAIT_IN: begin
          if (take_pair) begin
            in_ack <= 1'b1;
            state  <= CALC;
          end
        end
        CALC: begin
          // Present result with its row flag
          if (sum_valid) begin
            out_req  <= 1'b1;
            data_out <= sum_result;
            row_end  <= last_elem;
            state    <= SEND;
          end
        end
        SEND: begin
          // Hold req and data until the consumer acks
          if (out_ack) begin
            out_req <= 1'b0;
            row_end <= 1'b0;
            state   <= WAIT_DROP;
          end
        end
        WAIT_DROP: begin
          if (!out_ack) begin
            if (last_elem) begin
              row_done <= 1'b1;
              state    <= IDLE;
            end else begin
              elem_cnt <= elem_cnt + IDX_ONE;
              state    <= WAIT_IN;
            end
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- logic/ntm_matrix_adder.sv
`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_adder #(
  parameter int DATA_SIZE  = ntm_arith_pkg::DATA_SIZE_DEFAULT,
  parameter int INDEX_SIZE = ntm_arith_pkg::INDEX_SIZE_DEFAULT
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Job control, configuration held from start until ready
  input  logic                   start,
  output logic                   ready,
  input  ntm_arith_pkg::op_t     operation,
  input  logic [DATA_SIZE-1:0]   modulo,
  input  logic [INDEX_SIZE-1:0]  size_i,
  input  logic [INDEX_SIZE-1:0]  size_j,

  // Input four-phase port
  input  logic                   in_req,
  output logic                   in_ack,
  input  logic [DATA_SIZE-1:0]   data_a,
  input  logic [DATA_SIZE-1:0]   data_b,

  // Output four-phase port
  output logic                   out_req,
  input  logic                   out_ack,
  output logic [DATA_SIZE-1:0]   data_out,
  output logic                   out_row_end,
  output logic                   out_last
);

  import ntm_arith_pkg::*;

  ////////////////////////////////////////
  // Types and signals
  ////////////////////////////////////////

  // NEXT issues the row start, DONE is the ready cycle
  typedef enum logic [1:0] {IDLE, ROW, NEXT, DONE} matrix_state_t;

  localparam logic [INDEX_SIZE-1:0] IDX_ONE = 1;

  matrix_state_t         state;
  logic [INDEX_SIZE-1:0] row_cnt;
  logic                  last_row;

  // Job settings captured at start
  op_t                   op_q;
  logic [DATA_SIZE-1:0]  mod_q;

  // Vector adder control
  logic                  vec_start;
  logic                  row_done;

  ////////////////////////////////////////
  // Decoded outputs
  ////////////////////////////////////////

  assign last_row  = (row_cnt == size_i - IDX_ONE);
  assign vec_start = (state == NEXT);
  assign ready     = (state == DONE);

  // Row counter stays on the row until its handshake ends
  assign out_last  = out_row_end && last_row;

  ////////////////////////////////////////
  // Row loop
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= IDLE;
      row_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          // Start ignored outside idle
          if (start) begin
            row_cnt <= '0;
            state   <= NEXT;
          end
        end
        NEXT: begin
          state <= ROW;
        end
        ROW: begin
          if (row_done) begin
            if (last_row) begin
              state <= DONE;
            end else begin
              row_cnt <= row_cnt + IDX_ONE;
              state   <= NEXT;
            end
          end
        end
        DONE: begin
          // Single ready cycle then back to idle
          state <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Operation and modulus latched once per job
  always_ff @(posedge CLK) begin
    if ((state == IDLE) && start) begin
      op_q  <= operation;
      mod_q <= modulo;
    end
  end

  ////////////////////////////////////////
  // Element loop of one row
  ////////////////////////////////////////

  ntm_vector_adder #(
    .DATA_SIZE(DATA_SIZE),
    .INDEX_SIZE(INDEX_SIZE)
  ) u_vector_adder (
    .CLK(CLK),
    .RST(RST),
    .start(vec_start),
    .operation(op_q),
    .modulo(mod_q),
    .size(size_j),
    .in_req(in_req),
    .in_ack(in_ack),
    .data_a(data_a),
    .data_b(data_b),
    .out_req(out_req),
    .out_ack(out_ack),
    .data_out(data_out),
    .row_end(out_row_end),
    .row_done(row_done)
  );

endmodule

`default_nettype wire

//--- logic/ntm_matrix_top.sv
`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_top #(
  parameter int DATA_SIZE  = ntm_arith_pkg::DATA_SIZE_DEFAULT,
  parameter int INDEX_SIZE = ntm_arith_pkg::INDEX_SIZE_DEFAULT
) (
  input  logic                   CLK,
  input  logic                   RST,

  // Host control
  input  logic                   start,
  output logic                   ready,
  input  ntm_arith_pkg::op_t     operation,
  input  logic [DATA_SIZE-1:0]   modulo,
  input  logic [INDEX_SIZE-1:0]  size_i,
  input  logic [INDEX_SIZE-1:0]  size_j,

  // Operand stream
  input  logic                   in_req,
  output logic                   in_ack,
  input  logic [DATA_SIZE-1:0]   data_a,
  input  logic [DATA_SIZE-1:0]   data_b,

  // Result stream
  output logic                   out_req,
  input  logic                   out_ack,
  output logic [DATA_SIZE-1:0]   data_out,
  output logic                   out_row_end,
  output logic                   out_last
);

  ////////////////////////////////////////
  // Matrix adder core
  ////////////////////////////////////////

  // Widths chosen here apply to the whole tree
  ntm_matrix_adder #(
    .DATA_SIZE(DATA_SIZE),
    .INDEX_SIZE(INDEX_SIZE)
  ) u_matrix_adder (
    .CLK(CLK),
    .RST(RST),
    .start(start),
    .ready(ready),
    .operation(operation),
    .modulo(modulo),
    .size_i(size_i),
    .size_j(size_j),
    .in_req(in_req),
    .in_ack(in_ack),
    .data_a(data_a),
    .data_b(data_b),
    .out_req(out_req),
    .out_ack(out_ack),
    .data_out(data_out),
    .out_row_end(out_row_end),
    .out_last(out_last)
  );

endmodule

`default_nettype wire

//--- include/ntm_matrix_checks.svh
`ifndef NTM_MATRIX_CHECKS_SVH
`define NTM_MATRIX_CHECKS_SVH
`default_nettype none

////////////////////////////////////////
// Compare tasks
////////////////////////////////////////

task automatic check_data(input string name, input logic [DATA_SIZE-1:0] expected,
                          input logic [DATA_SIZE-1:0] actual);
  if (actual !== expected) begin
    $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
    error_count++;
    abort_run();
  end
endtask

task automatic check_flag(input string name, input logic expected, input logic actual);
  if (actual !== expected) begin
    $display("ERR %s expected 0x%h actual 0x%h", name, expected, actual);
    error_count++;
    abort_run();
  end
endtask

////////////////////////////////////////
// Reference model and operands
////////////////////////////////////////

// True remainder of the sum or of the difference shifted by one modulus
function automatic logic [DATA_SIZE-1:0] model_result(input op_t op,
    input logic [DATA_SIZE-1:0] modulus, input logic [DATA_SIZE-1:0] a,
    input logic [DATA_SIZE-1:0] b);
  longint unsigned m;
  longint unsigned x;
  longint unsigned y;
  longint unsigned r;
  m = 64'(modulus);
  x = 64'(a);
  y = 64'(b);
  if (op == OP_ADD) begin
    r = (x + y) % m;
  end else begin
    r = (x + m - y) % m;
  end
  return DATA_SIZE'(r);
endfunction

// Uniform-ish value in 0 .. bound-1
function automatic logic [DATA_SIZE-1:0] rand_below(input logic [DATA_SIZE-1:0] bound);
  return $unsigned($random(seed)) % bound;
endfunction

////////////////////////////////////////
// Handshake drivers
////////////////////////////////////////

// Raise in_req with the pair, ack not awaited here
task automatic present_pair(input logic [DATA_SIZE-1:0] a, input logic [DATA_SIZE-1:0] b);
  @(posedge CLK);
  in_req <= 1'b1;
  data_a <= a;
  data_b <= b;
endtask

// Phases 2 to 4 of the input handshake
task automatic complete_pair();
  @(negedge CLK);
  while (!in_ack) @(negedge CLK);
  @(posedge CLK);
  in_req <= 1'b0;
  @(negedge CLK);
  while (in_ack) @(negedge CLK);
endtask

task automatic send_pair(input logic [DATA_SIZE-1:0] a, input logic [DATA_SIZE-1:0] b);
  present_pair(a, b);
  complete_pair();
endtask

task automatic take_result(input logic [DATA_SIZE-1:0] expected, input logic row_end_exp,
                           input logic last_exp, input int delay);
  @(negedge CLK);
  while (!out_req) @(negedge CLK);
  check_data("data_out", expected, data_out);
  check_flag("out_row_end", row_end_exp, out_row_end);
  check_flag("out_last", last_exp, out_last);
  // Result must hold, and no new pair taken, while ack is withheld
  repeat (delay) begin
    @(negedge CLK);
    check_flag("out_req", 1'b1, out_req);
    check_data("data_out", expected, data_out);
    check_flag("in_ack", 1'b0, in_ack);
  end
  @(posedge CLK);
  out_ack <= 1'b1;
  @(negedge CLK);
  while (out_req) @(negedge CLK);
  @(posedge CLK);
  out_ack <= 1'b0;
endtask

`default_nettype wire
`endif

//--- tests/ntm_matrix_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ntm_matrix_tb;

  import ntm_arith_pkg::*;

  localparam int DATA_SIZE  = DATA_SIZE_DEFAULT;
  localparam int INDEX_SIZE = INDEX_SIZE_DEFAULT;
  localparam int CLK_PERIOD = 100;
  // Sum of the element counts of all jobs below
  localparam int TOTAL_ELEMENTS = 41;
  localparam int READY_WAIT = 10;

  logic                  CLK;
  logic                  RST;
  logic                  start;
  logic                  ready;
  op_t                   operation;
  logic [DATA_SIZE-1:0]  modulo;
  logic [INDEX_SIZE-1:0] size_i;
  logic [INDEX_SIZE-1:0] size_j;
  logic                  in_req;
  logic                  in_ack;
  logic [DATA_SIZE-1:0]  data_a;
  logic [DATA_SIZE-1:0]  data_b;
  logic                  out_req;
  logic                  out_ack;
  logic [DATA_SIZE-1:0]  data_out;
  logic                  out_row_end;
  logic                  out_last;

  integer seed = 2933;
  int error_count = 0;
  int ready_count = 0;
  int ready_base = 0;
  // Operand pairs of the next job in row-major order
  logic [DATA_SIZE-1:0] a_q[$];
  logic [DATA_SIZE-1:0] b_q[$];

  `include "ntm_matrix_checks.svh"

  ////////////////////////////////////////
  // Clock, DUT, monitors
  ////////////////////////////////////////

  always #(CLK_PERIOD / 2) CLK = ~CLK;

  // Counts every ready cycle across all jobs
  always @(posedge CLK) begin
    if (ready) begin
      ready_count <= ready_count + 1;
    end
  end

  ntm_matrix_top #(
    .DATA_SIZE(DATA_SIZE),
    .INDEX_SIZE(INDEX_SIZE)
  ) u_ntm_matrix_top (
    .CLK(CLK),
    .RST(RST),
    .start(start),
    .ready(ready),
    .operation(operation),
    .modulo(modulo),
    .size_i(size_i),
    .size_j(size_j),
    .in_req(in_req),
    .in_ack(in_ack),
    .data_a(data_a),
    .data_b(data_b),
    .out_req(out_req),
    .out_ack(out_ack),
    .data_out(data_out),
    .out_row_end(out_row_end),
    .out_last(out_last)
  );

  // Generous budget per element
  initial begin
    #(TOTAL_ELEMENTS * 40 * CLK_PERIOD);
    $display("Timeout, the run did not finish in time");
    abort_run();
  end

  task automatic abort_run();
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  endtask

  ////////////////////////////////////////
  // Job helpers
  ////////////////////////////////////////

  task automatic start_job(input op_t op, input logic [DATA_SIZE-1:0] m,
                           input int rows, input int cols);
    @(posedge CLK);
    operation  <= op;
    modulo     <= m;
    size_i     <= INDEX_SIZE'(rows);
    size_j     <= INDEX_SIZE'(cols);
    start      <= 1'b1;
    ready_base = ready_count;
    @(posedge CLK);
    start <= 1'b0;
  endtask

  // Exactly one ready cycle after the final handshake
  task automatic wait_ready();
    int waited;
    bit seen;
    waited = 0;
    seen = 1'b0;
    while (!seen && waited < READY_WAIT) begin
      @(negedge CLK);
      seen = ready;
      waited++;
    end
    if (!seen) begin
      $display("ready never pulsed after the final result of the job");
      abort_run();
    end
    @(negedge CLK);
    check_flag("ready", 1'b0, ready);
    check_flag("ready", 1'b1, (ready_count - ready_base) == 1);
  endtask

  // Early mode offers the next pair while a result is still pending
  task automatic run_job(input op_t op, input logic [DATA_SIZE-1:0] m, input int rows,
                         input int cols, input int max_delay, input bit early);
    int total;
    int delay;
    logic [DATA_SIZE-1:0] expected;
    total = rows * cols;
    start_job(op, m, rows, cols);
    for (int idx = 0; idx < total; idx++) begin
      if (early && idx > 0) begin
        complete_pair();
      end else begin
        send_pair(a_q[idx], b_q[idx]);
      end
      if (early && idx + 1 < total) begin
        present_pair(a_q[idx + 1], b_q[idx + 1]);
      end
      expected = model_result(op, m, a_q[idx], b_q[idx]);
      delay = int'($unsigned($random(seed)) % (max_delay + 1));
      // No ready before the last handshake
      check_flag("ready", 1'b0, ready_count != ready_base);
      take_result(expected, (idx % cols) == cols - 1, idx == total - 1, delay);
    end
    wait_ready();
    a_q.delete();
    b_q.delete();
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic check_reset_values();
    @(negedge CLK);
    check_flag("ready", 1'b0, ready);
    check_flag("in_ack", 1'b0, in_ack);
    check_flag("out_req", 1'b0, out_req);
    check_flag("out_row_end", 1'b0, out_row_end);
    check_flag("out_last", 1'b0, out_last);
    check_data("data_out", '0, data_out);
  endtask

  task automatic test_addition();
    repeat (12) begin
      a_q.push_back(rand_below(32'd1000));
      b_q.push_back(rand_below(32'd1000));
    end
    run_job(OP_ADD, 32'd1000, 3, 4, 0, 1'b0);
  endtask

  // Even elements have a below b and must wrap
  task automatic test_subtract_wrap();
    logic [DATA_SIZE-1:0] x;
    for (int idx = 0; idx < 6; idx++) begin
      x = rand_below(32'd96);
      if (idx % 2 == 0) begin
        a_q.push_back(x);
        b_q.push_back(x + 32'd1 + rand_below(32'd96 - x));
      end else begin
        b_q.push_back(x);
        a_q.push_back(x + rand_below(32'd97 - x));
      end
    end
    run_job(OP_SUB, 32'd97, 2, 3, 0, 1'b0);
  endtask

  // Large modulus so the guard bit is exercised
  task automatic test_boundaries();
    logic [DATA_SIZE-1:0] m;
    m = 32'hFFFF_FFFB;
    a_q = '{32'd1, m - 32'd1, m - 32'd1};
    b_q = '{m - 32'd1, 32'd1, m - 32'd1};
    run_job(OP_ADD, m, 1, 3, 0, 1'b0);
    a_q = '{m - 32'd1, 32'd0};
    b_q = '{m - 32'd1, 32'd0};
    run_job(OP_SUB, m, 1, 2, 0, 1'b0);
  endtask

  task automatic test_back_pressure();
    repeat (9) begin
      a_q.push_back(rand_below(32'd65521));
      b_q.push_back(rand_below(32'd65521));
    end
    run_job(OP_ADD, 32'd65521, 3, 3, 5, 1'b1);
  endtask

  task automatic test_back_to_back();
    a_q.push_back(rand_below(32'd13));
    b_q.push_back(rand_below(32'd13));
    run_job(OP_ADD, 32'd13, 1, 1, 0, 1'b0);
    repeat (8) begin
      a_q.push_back(rand_below(32'd13));
      b_q.push_back(rand_below(32'd13));
    end
    run_job(OP_SUB, 32'd13, 4, 2, 0, 1'b0);
  endtask

  initial begin
    CLK = 1'b0;
    RST       <= 1'b1;
    start     <= 1'b0;
    operation <= OP_ADD;
    modulo    <= '0;
    size_i    <= '0;
    size_j    <= '0;
    in_req    <= 1'b0;
    data_a    <= '0;
    data_b    <= '0;
    out_ack   <= 1'b0;
    repeat (2) @(posedge CLK);
    RST <= 1'b0;
    check_reset_values();
    test_addition();
    test_subtract_wrap();
    test_boundaries();
    test_back_pressure();
    test_back_to_back();
    if (error_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
logic/ntm_arith_pkg.sv
logic/ntm_scalar_adder.sv
logic/ntm_vector_adder.sv
logic/ntm_matrix_adder.sv
logic/ntm_matrix_top.sv
tests/ntm_matrix_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       := ntm_matrix_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Test failed
PASS_MSG  := Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: no result in log"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
